//--- common/hci_ecc_pkg.sv
// ----------------------------------------------------------------------
// hci ecc cluster slice shared types
// ----------------------------------------------------------------------

package hci_ecc_pkg;

  // bus geometry
  localparam int unsigned DATA_W     = 32;
  localparam int unsigned ECC_W      = 7;
  localparam int unsigned ADDR_W     = 8;
  localparam int unsigned BE_W       = DATA_W / 8;
  localparam int unsigned BANK_WORDS = 2 ** ADDR_W;
  localparam int unsigned NB_PORTS   = 2;

  typedef logic [DATA_W-1:0]           data_t;
  typedef logic [ECC_W-1:0]            ecc_t;
  typedef logic [ADDR_W-1:0]           addr_t;
  typedef logic [BE_W-1:0]             be_t;
  typedef logic [ECC_W-1:0]            syndrome_t;
  // bit 0 single error corrected, bit 1 double error detected
  typedef logic [1:0]                  err_t;
  typedef logic [$clog2(NB_PORTS)-1:0] port_idx_t;

  // one parity mask per check bit
  typedef logic [ECC_W-1:0][DATA_W-1:0] ecc_masks_t;

  // protected side, wen high means read
  typedef struct packed {
    logic  req;
    addr_t add;
    logic  wen;
    be_t   be;
    data_t data;
    ecc_t  ecc;
  } ecc_req_t;

  typedef struct packed {
    logic  r_valid;
    data_t r_data;
    ecc_t  r_ecc;
  } ecc_rsp_t;

  // plain side toward the bank
  typedef struct packed {
    logic  req;
    addr_t add;
    logic  wen;
    be_t   be;
    data_t data;
  } mem_req_t;

  typedef struct packed {
    logic  r_valid;
    data_t r_data;
  } mem_rsp_t;

  // hsiao columns: first 32 weight-3 codes in ascending order
  // all columns odd and distinct, none equal to a check-bit column
  function automatic ecc_masks_t gen_ecc_masks();
    ecc_masks_t  masks;
    int unsigned col_idx;
    masks   = '0;
    col_idx = 0;
    for (int unsigned code = 1; code < 2 ** ECC_W; code++) begin
      if ($countones(code[ECC_W-1:0]) == 3 && col_idx < DATA_W) begin
        for (int unsigned k = 0; k < ECC_W; k++) begin
          masks[k][col_idx] = code[k];
        end
        col_idx++;
      end
    end
    return masks;
  endfunction

  localparam ecc_masks_t ECC_MASKS = gen_ecc_masks();

  // check bit k is even parity over the data bits of mask k
  function automatic ecc_t secded_encode(data_t data);
    ecc_t ecc;
    for (int unsigned k = 0; k < ECC_W; k++) begin
      ecc[k] = ^(data & ECC_MASKS[k]);
    end
    return ecc;
  endfunction

endpackage

//--- ecc/secded_39_32_dec.sv
// ----------------------------------------------------------------------
// secded 39/32 decoder
// ----------------------------------------------------------------------

module secded_39_32_dec (
  input  hci_ecc_pkg::data_t     data_i,
  input  hci_ecc_pkg::ecc_t      ecc_i,
  output hci_ecc_pkg::data_t     data_o,
  output hci_ecc_pkg::syndrome_t syndrome_o,
  output hci_ecc_pkg::err_t      err_o
);

  import hci_ecc_pkg::*;

  syndrome_t syndrome;
  data_t     flip_mask;

  // received check bits against the ones recomputed from the data
  assign syndrome = ecc_i ^ secded_encode(data_i);

  // look for a data column equal to the syndrome
  always_comb begin : find_column
    ecc_t column;
    flip_mask = '0;
    for (int unsigned j = 0; j < DATA_W; j++) begin
      for (int unsigned k = 0; k < ECC_W; k++) begin
        column[k] = ECC_MASKS[k][j];
      end
      if (syndrome == column) begin
        flip_mask[j] = 1'b1;
      end
    end
  end

  // only one bit can match since the columns are distinct
  assign data_o = data_i ^ flip_mask;

  // odd weight is a single error, even nonzero weight a double error
  // an odd syndrome with no data column is a check-bit hit, data left as is
  always_comb begin
    err_o = 2'b00;
    if (syndrome != '0) begin
      if (^syndrome) begin
        err_o = 2'b01;
      end else begin
        err_o = 2'b10;
      end
    end
  end

  assign syndrome_o = syndrome;

  // no clock here, so check every settled evaluation
  always_comb begin
    assert final (err_o != 2'b11)
      else $error("secded decoder flags single and double error at once");
  end

endmodule

//--- ecc/hci_core_ecc_dec.sv
// ----------------------------------------------------------------------
// per-port ecc removal
// ----------------------------------------------------------------------

module hci_core_ecc_dec (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  hci_ecc_pkg::ecc_req_t  bus_in_req_i,
  output logic                   bus_in_gnt_o,
  output hci_ecc_pkg::ecc_rsp_t  bus_in_rsp_o,
  output hci_ecc_pkg::mem_req_t  bus_out_req_o,
  input  logic                   bus_out_gnt_i,
  input  hci_ecc_pkg::mem_rsp_t  bus_out_rsp_i,
  output hci_ecc_pkg::syndrome_t syndrome_o,
  output hci_ecc_pkg::err_t      err_o
);

  import hci_ecc_pkg::*;

  data_t     data_corrected;
  syndrome_t syndrome_raw;
  err_t      err_raw;

  // correct the write data and its check bits
  secded_39_32_dec i_secded_dec (
    .data_i     ( bus_in_req_i.data ),
    .ecc_i      ( bus_in_req_i.ecc  ),
    .data_o     ( data_corrected    ),
    .syndrome_o ( syndrome_raw      ),
    .err_o      ( err_raw           )
  );

  // request side, check bits dropped
  assign bus_out_req_o.req  = bus_in_req_i.req;
  assign bus_out_req_o.add  = bus_in_req_i.add;
  assign bus_out_req_o.wen  = bus_in_req_i.wen;
  assign bus_out_req_o.be   = bus_in_req_i.be;
  assign bus_out_req_o.data = data_corrected;
  assign bus_in_gnt_o       = bus_out_gnt_i;

  // status only meaningful while a request is up
  assign syndrome_o = bus_in_req_i.req ? syndrome_raw : '0;
  assign err_o      = bus_in_req_i.req ? err_raw : '0;

  // response side, fresh check bits on the read data
  assign bus_in_rsp_o.r_valid = bus_out_rsp_i.r_valid;
  assign bus_in_rsp_o.r_data  = bus_out_rsp_i.r_data;
  assign bus_in_rsp_o.r_ecc   = secded_encode(bus_out_rsp_i.r_data);

  // every response needs a transfer on this port one cycle before
  assert property (@(posedge clk_i) disable iff (reset_i)
    bus_out_rsp_i.r_valid |-> $past(bus_in_req_i.req && bus_out_gnt_i))
    else $error("r_valid without a grant in the previous cycle");

endmodule

//--- src/hci_rr_arbiter.sv
// ----------------------------------------------------------------------
// round-robin bank arbiter
// ----------------------------------------------------------------------

module hci_rr_arbiter (
  input  logic                                              clk_i,
  input  logic                                              reset_i,
  input  hci_ecc_pkg::mem_req_t [hci_ecc_pkg::NB_PORTS-1:0] port_req_i,
  output logic                  [hci_ecc_pkg::NB_PORTS-1:0] port_gnt_o,
  output hci_ecc_pkg::mem_rsp_t [hci_ecc_pkg::NB_PORTS-1:0] port_rsp_o,
  output hci_ecc_pkg::mem_req_t                             mem_req_o,
  input  hci_ecc_pkg::data_t                                mem_rdata_i
);

  import hci_ecc_pkg::*;

  port_idx_t rr_ptr_q;
  port_idx_t winner;
  logic      win_valid;
  port_idx_t rsp_idx_q;
  logic      rsp_valid_q;
  port_idx_t ptr_next;

  // first requester at or after the pointer wins
  always_comb begin : pick_winner
    int unsigned cand;
    winner    = rr_ptr_q;
    win_valid = 1'b0;
    for (int unsigned i = 0; i < NB_PORTS; i++) begin
      cand = (rr_ptr_q + i) % NB_PORTS;
      if (!win_valid && port_req_i[cand].req) begin
        win_valid = 1'b1;
        winner    = port_idx_t'(cand);
      end
    end
  end

  always_comb begin
    port_gnt_o         = '0;
    port_gnt_o[winner] = win_valid;
  end

  // with no requester the pointed port is idle, so req stays low
  assign mem_req_o = port_req_i[winner];

  // pointer lands just past the winner
  assign ptr_next = (winner == port_idx_t'(NB_PORTS - 1)) ? '0 : winner + 1'b1;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_ptr_q    <= '0;
      rsp_idx_q   <= '0;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= win_valid;
      if (win_valid) begin
        rr_ptr_q  <= ptr_next;
        rsp_idx_q <= winner;
      end
    end
  end

  // bank data goes to everyone, r_valid only to last cycle's winner
  always_comb begin
    for (int unsigned p = 0; p < NB_PORTS; p++) begin
      port_rsp_o[p].r_valid = rsp_valid_q && (rsp_idx_q == port_idx_t'(p));
      port_rsp_o[p].r_data  = mem_rdata_i;
    end
  end

  assert property (@(posedge clk_i) disable iff (reset_i) $onehot0(port_gnt_o))
    else $error("more than one port granted");

endmodule

//--- src/hci_sram_bank.sv
// ----------------------------------------------------------------------
// shared sram bank
// ----------------------------------------------------------------------

module hci_sram_bank (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  hci_ecc_pkg::mem_req_t mem_req_i,
  output hci_ecc_pkg::data_t    rdata_o
);

  import hci_ecc_pkg::*;

  data_t mem_q [BANK_WORDS];
  logic  wr_en;
  logic  rd_en;

  // wen low is a write, wen high a read
  assign wr_en = mem_req_i.req && !mem_req_i.wen;
  assign rd_en = mem_req_i.req && mem_req_i.wen;

  // byte-enabled write, lands on the grant edge
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      for (int unsigned b = 0; b < BE_W; b++) begin
        if (mem_req_i.be[b]) begin
          mem_q[mem_req_i.add][b*8 +: 8] <= mem_req_i.data[b*8 +: 8];
        end
      end
    end
  end

  // registered read, valid one cycle after the request
  // held value on writes and idle cycles
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rdata_o <= '0;
    end else if (rd_en) begin
      rdata_o <= mem_q[mem_req_i.add];
    end
  end

endmodule

//--- src/hci_ecc_subsystem.sv
// ----------------------------------------------------------------------
// ecc cluster slice top
// ----------------------------------------------------------------------

module hci_ecc_subsystem (
  input  logic                                               clk_i,
  input  logic                                               reset_i,
  input  hci_ecc_pkg::ecc_req_t  [hci_ecc_pkg::NB_PORTS-1:0] bus_req_i,
  output logic                   [hci_ecc_pkg::NB_PORTS-1:0] bus_gnt_o,
  output hci_ecc_pkg::ecc_rsp_t  [hci_ecc_pkg::NB_PORTS-1:0] bus_rsp_o,
  output hci_ecc_pkg::syndrome_t [hci_ecc_pkg::NB_PORTS-1:0] syndrome_o,
  output hci_ecc_pkg::err_t      [hci_ecc_pkg::NB_PORTS-1:0] err_o
);

  import hci_ecc_pkg::*;

  // plain side of each port
  mem_req_t [NB_PORTS-1:0] port_req;
  logic     [NB_PORTS-1:0] port_gnt;
  mem_rsp_t [NB_PORTS-1:0] port_rsp;

  // arbiter to bank
  mem_req_t bank_req;
  data_t    bank_rdata;

  for (genvar p = 0; p < NB_PORTS; p++) begin : gen_port
    hci_core_ecc_dec i_ecc_dec (
      .clk_i         ( clk_i         ),
      .reset_i       ( reset_i       ),
      .bus_in_req_i  ( bus_req_i[p]  ),
      .bus_in_gnt_o  ( bus_gnt_o[p]  ),
      .bus_in_rsp_o  ( bus_rsp_o[p]  ),
      .bus_out_req_o ( port_req[p]   ),
      .bus_out_gnt_i ( port_gnt[p]   ),
      .bus_out_rsp_i ( port_rsp[p]   ),
      .syndrome_o    ( syndrome_o[p] ),
      .err_o         ( err_o[p]      )
    );
  end

  hci_rr_arbiter i_arbiter (
    .clk_i       ( clk_i      ),
    .reset_i     ( reset_i    ),
    .port_req_i  ( port_req   ),
    .port_gnt_o  ( port_gnt   ),
    .port_rsp_o  ( port_rsp   ),
    .mem_req_o   ( bank_req   ),
    .mem_rdata_i ( bank_rdata )
  );

  hci_sram_bank i_bank (
    .clk_i     ( clk_i      ),
    .reset_i   ( reset_i    ),
    .mem_req_i ( bank_req   ),
    .rdata_o   ( bank_rdata )
  );

endmodule

//--- testbench/tb_hci_ecc.sv
// ----------------------------------------------------------------------
// hci ecc slice testbench
// ----------------------------------------------------------------------

module tb_hci_ecc;

  import hci_ecc_pkg::*;

  localparam int TIMEOUT   = 20;
  localparam int CONC_REQS = 4;

  logic                     clk;
  logic                     reset;
  ecc_req_t  [NB_PORTS-1:0] bus_req;
  logic      [NB_PORTS-1:0] bus_gnt;
  ecc_rsp_t  [NB_PORTS-1:0] bus_rsp;
  syndrome_t [NB_PORTS-1:0] port_syndrome;
  err_t      [NB_PORTS-1:0] port_err;

  // shadow copy of the bank and the addresses written so far
  data_t shadow_mem [BANK_WORDS];
  addr_t written_q [$];

  hci_ecc_subsystem dut (
    .clk_i      ( clk           ),
    .reset_i    ( reset         ),
    .bus_req_i  ( bus_req       ),
    .bus_gnt_o  ( bus_gnt       ),
    .bus_rsp_o  ( bus_rsp       ),
    .syndrome_o ( port_syndrome ),
    .err_o      ( port_err      )
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Something failed");
    $fatal(1, "run stopped");
  endtask

  task automatic check_data(input string what, input data_t got, input data_t exp);
    if (got !== exp) begin
      $display("error at time %0t: %s got %h expected %h", $time, what, got, exp);
      abort_run("data mismatch");
    end
  endtask

  task automatic check_ecc(input string what, input ecc_t got, input ecc_t exp);
    if (got !== exp) begin
      $display("error at time %0t: %s got %h expected %h", $time, what, got, exp);
      abort_run("check bit mismatch");
    end
  endtask

  task automatic check_err(input string what, input err_t got, input err_t exp);
    if (got !== exp) begin
      $display("error at time %0t: %s got %b expected %b", $time, what, got, exp);
      abort_run("error code mismatch");
    end
  endtask

  task automatic check_syndrome(input string what, input syndrome_t got, input syndrome_t exp);
    if (got !== exp) begin
      $display("error at time %0t: %s got %h expected %h", $time, what, got, exp);
      abort_run("syndrome mismatch");
    end
  endtask

  function automatic ecc_req_t make_req(addr_t add, logic wen, be_t be, data_t data, ecc_t ecc);
    ecc_req_t rq;
    rq      = '0;
    rq.req  = 1'b1;
    rq.add  = add;
    rq.wen  = wen;
    rq.be   = be;
    rq.data = data;
    rq.ecc  = ecc;
    return rq;
  endfunction

  function automatic addr_t pick_written();
    return written_q[$urandom % written_q.size()];
  endfunction

  // one request on one port, status sampled at the falling edge of the grant cycle
  task automatic transfer(input int p, input ecc_req_t rq, output err_t err,
                          output syndrome_t syn, output ecc_rsp_t rsp);
    int waited;
    @(posedge clk);
    #1;
    bus_req[p] = rq;
    waited     = 0;
    @(negedge clk);
    while (!bus_gnt[p]) begin
      waited++;
      if (waited > TIMEOUT) abort_run($sformatf("timeout waiting for gnt on port %0d", p));
      @(negedge clk);
    end
    err = port_err[p];
    syn = port_syndrome[p];
    @(posedge clk);
    #1;
    bus_req[p] = '0;
    waited     = 0;
    @(negedge clk);
    while (!bus_rsp[p].r_valid) begin
      waited++;
      if (waited > TIMEOUT) abort_run($sformatf("timeout waiting for r_valid on port %0d", p));
      @(negedge clk);
    end
    rsp = bus_rsp[p];
  endtask

  // stored is the word the bank should hold after correction
  task automatic write_word(input int p, input addr_t add, input data_t data, input ecc_t ecc,
                            input be_t be, input err_t exp_err, input syndrome_t exp_syn,
                            input data_t stored);
    err_t      err;
    syndrome_t syn;
    ecc_rsp_t  rsp;
    transfer(p, make_req(add, 1'b0, be, data, ecc), err, syn, rsp);
    check_err("write err", err, exp_err);
    check_syndrome("write syndrome", syn, exp_syn);
    for (int b = 0; b < BE_W; b++) begin
      if (be[b]) shadow_mem[add][b*8 +: 8] = stored[b*8 +: 8];
    end
    written_q.push_back(add);
  endtask

  task automatic read_check(input int p, input addr_t add);
    err_t      err;
    syndrome_t syn;
    ecc_rsp_t  rsp;
    // all-zero data with zero check bits is a valid codeword
    transfer(p, make_req(add, 1'b1, '1, '0, '0), err, syn, rsp);
    check_err("read err", err, 2'b00);
    check_syndrome("read syndrome", syn, '0);
    check_data("read data", rsp.r_data, shadow_mem[add]);
    check_ecc("read ecc", rsp.r_ecc, secded_encode(shadow_mem[add]));
  endtask

  task automatic test_clean();
    addr_t add;
    data_t data;
    for (int p = 0; p < NB_PORTS; p++) begin
      add  = addr_t'($urandom);
      data = data_t'($urandom);
      write_word(p, add, data, secded_encode(data), '1, 2'b00, '0, data);
      read_check(p, add);
    end
  endtask

  // a flipped data bit yields its own column as syndrome
  task automatic test_single_data();
    addr_t add;
    data_t data;
    data_t flip;
    add  = addr_t'($urandom);
    data = data_t'($urandom);
    flip = data_t'(1) << ($urandom % DATA_W);
    write_word(0, add, data ^ flip, secded_encode(data), '1, 2'b01, secded_encode(flip), data);
    read_check(1, add);
  endtask

  task automatic test_single_ecc();
    addr_t add;
    data_t data;
    ecc_t  flip;
    add  = addr_t'($urandom);
    data = data_t'($urandom);
    flip = ecc_t'(1) << ($urandom % ECC_W);
    write_word(1, add, data, secded_encode(data) ^ flip, '1, 2'b01, flip, data);
    read_check(0, add);
  endtask

  // two distinct data bits, the bank keeps the damaged word
  task automatic test_double();
    addr_t add;
    data_t data;
    data_t flip;
    int    i;
    int    j;
    add  = addr_t'($urandom);
    data = data_t'($urandom);
    i    = $urandom % DATA_W;
    j    = (i + 1 + $urandom % (DATA_W - 1)) % DATA_W;
    flip = (data_t'(1) << i) | (data_t'(1) << j);
    write_word(0, add, data ^ flip, secded_encode(data), '1, 2'b10, secded_encode(flip),
               data ^ flip);
    read_check(0, add);
  endtask

  task automatic test_partial();
    addr_t add;
    data_t data;
    be_t   be;
    for (int p = 0; p < NB_PORTS; p++) begin
      add  = addr_t'($urandom);
      data = data_t'($urandom);
      write_word(p, add, data, secded_encode(data), '1, 2'b00, '0, data);
      // 1 to 14, never all bytes
      be   = be_t'($urandom % 14 + 1);
      data = data_t'($urandom);
      write_word(p, add, data, secded_encode(data), be, 2'b00, '0, data);
      read_check(p, add);
    end
  endtask

  // both ports keep reading, grants must alternate
  task automatic test_concurrent();
    addr_t cur_addr [NB_PORTS];
    int    done [NB_PORTS];
    int    last_port;
    int    gnt_port;
    int    rsp_port;
    addr_t rsp_addr;
    logic  rsp_due;
    int    cycles;
    last_port = -1;
    gnt_port  = 0;
    rsp_port  = 0;
    rsp_addr  = '0;
    rsp_due   = 1'b0;
    cycles    = 0;
    @(posedge clk);
    #1;
    for (int p = 0; p < NB_PORTS; p++) begin
      done[p]     = 0;
      cur_addr[p] = pick_written();
      bus_req[p]  = make_req(cur_addr[p], 1'b1, '1, '0, '0);
    end
    while (done[0] < CONC_REQS || done[1] < CONC_REQS || rsp_due) begin
      @(negedge clk);
      cycles++;
      if (cycles > TIMEOUT * CONC_REQS) abort_run("timeout in concurrent transfers");
      if (rsp_due) begin
        if (!bus_rsp[rsp_port].r_valid || bus_rsp[1-rsp_port].r_valid) begin
          abort_run("r_valid missing or on the wrong port");
        end
        check_data("concurrent data", bus_rsp[rsp_port].r_data, shadow_mem[rsp_addr]);
        check_ecc("concurrent ecc", bus_rsp[rsp_port].r_ecc, secded_encode(shadow_mem[rsp_addr]));
      end
      rsp_due = 1'b0;
      if (bus_gnt != '0) begin
        if (&bus_gnt) abort_run("both ports granted in one cycle");
        gnt_port = bus_gnt[1] ? 1 : 0;
        if (gnt_port == last_port && done[1-gnt_port] < CONC_REQS) begin
          abort_run("grants did not alternate between the ports");
        end
        last_port = gnt_port;
        rsp_due   = 1'b1;
        rsp_port  = gnt_port;
        rsp_addr  = cur_addr[gnt_port];
      end
      @(posedge clk);
      #1;
      // granted port moves on to its next read or drops req
      if (rsp_due) begin
        done[gnt_port]++;
        if (done[gnt_port] < CONC_REQS) begin
          cur_addr[gnt_port] = pick_written();
          bus_req[gnt_port]  = make_req(cur_addr[gnt_port], 1'b1, '1, '0, '0);
        end else begin
          bus_req[gnt_port] = '0;
        end
      end
    end
  endtask

  initial begin
    reset   = 1'b1;
    bus_req = '0;
    void'($urandom(56977));
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    test_clean();
    test_single_data();
    test_single_ecc();
    test_double();
    test_partial();
    test_concurrent();
    $display("Everything OK");
    $finish;
  end

endmodule

//--- tb.f
common/hci_ecc_pkg.sv
ecc/secded_39_32_dec.sv
ecc/hci_core_ecc_dec.sv
src/hci_rr_arbiter.sv
src/hci_sram_bank.sv
src/hci_ecc_subsystem.sv
testbench/tb_hci_ecc.sv
